/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP       := exec_tb
FILELIST  := files.f
SIMFLAGS  := +verilator+error+limit+100

SIM     := obj_dir/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard logic/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	./$(SIM) $(SIMFLAGS) 2>&1 | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

/* files.f */
+incdir+logic
logic/exec_pkg.sv
logic/exec_cmp_if.sv
logic/exec_alu.sv
logic/exec_cfu.sv
logic/exec_wb_reg.sv
logic/exec_stage.sv
verification/exec_assertions.sv
verification/exec_tb.sv

/* logic/exec_alu.sv */
// Combinational integer ALU, zero cycles of latency
// Compare flags always reflect lhs against rhs, whatever op is selected,
// so branches may use any ALU op code
// Shifts use rhs[4:0] only

`include "exec_defines.svh"

module exec_alu (
    input  logic [`EXEC_XLEN-1:0] lhs,    // Left operand
    input  logic [`EXEC_XLEN-1:0] rhs,    // Right operand
    input  exec_pkg::alu_op_t     op,     // Operation select
    output logic [`EXEC_XLEN-1:0] result, // Operation result
    exec_cmp_if.alu               cmp     // Sum and flags for the CFU
);

    localparam int MSB = `EXEC_XLEN - 1;

    // ------------------------------
    // Adder and subtractor
    // ------------------------------

    logic [`EXEC_XLEN-1:0] sum;   // lhs + rhs
    logic [`EXEC_XLEN:0]   diff;  // lhs - rhs with borrow on top
    logic                  eq;
    logic                  lt;
    logic                  ltu;
    logic [4:0]            shamt; // Shift amount

    assign sum  = lhs + rhs;
    assign diff = {1'b0, lhs} - {1'b0, rhs}; // Shared by sub and all compares

    assign eq  = (diff[MSB:0] == '0);        // Zero difference
    assign ltu = diff[`EXEC_XLEN];           // Borrow out means lhs < rhs

    // Signs differ: the negative one is smaller, else the difference sign decides
    assign lt  = (lhs[MSB] != rhs[MSB]) ? lhs[MSB] : diff[MSB];

    assign shamt = rhs[4:0];

    // Publish for branch resolution
    assign cmp.add_out = sum;
    assign cmp.cmp_eq  = eq;
    assign cmp.cmp_lt  = lt;
    assign cmp.cmp_ltu = ltu;

    // ------------------------------
    // Result select
    // ------------------------------

    always_comb begin
        case (op)
            exec_pkg::alu_add:  result = sum;
            exec_pkg::alu_sub:  result = diff[MSB:0];
            exec_pkg::alu_and:  result = lhs & rhs;
            exec_pkg::alu_or:   result = lhs | rhs;
            exec_pkg::alu_xor:  result = lhs ^ rhs;
            exec_pkg::alu_sll:  result = lhs << shamt;
            exec_pkg::alu_srl:  result = lhs >> shamt;
            exec_pkg::alu_sra:  result = $signed(lhs) >>> shamt; // Sign fill
            exec_pkg::alu_slt:  result = {{MSB{1'b0}}, lt};
            exec_pkg::alu_sltu: result = {{MSB{1'b0}}, ltu};
            default:            result = '0; // Unused codes
        endcase
    end

endmodule

/* logic/exec_cfu.sv */
// Branch and jump resolution for the execute stage
// Control flow request is held until acked, then remembered until the
// instruction is accepted, so the fetch side sees each request only once
// Target must stay stable, so decode holds pc, imm and rs1 while valid

`include "exec_defines.svh"

module exec_cfu (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  logic                  valid,     // Instruction present in stage
    input  logic                  accept,    // Instruction leaves this cycle
    input  exec_pkg::cfu_op_t     op,        // Control flow operation
    input  logic [`EXEC_XLEN-1:0] pc,        // Current program counter
    input  logic [`EXEC_XLEN-1:0] rs1_data,  // Base for jalr
    input  logic [`EXEC_XLEN-1:0] imm,       // Branch or jump offset
    exec_cmp_if.cfu               cmp,       // Flags from the ALU
    output logic                  cf_valid,  // Control flow change request
    input  logic                  cf_ack,    // Request taken by fetch
    output logic [`EXEC_XLEN-1:0] cf_target, // Destination address
    output logic                  finished   // Stage may hand on the instruction
);

    // ------------------------------
    // Taken decision
    // ------------------------------

    logic taken;     // Condition holds or unconditional jump
    logic cf_need;   // This instruction changes control flow
    logic ack_seen;  // Sticky, request already acked
    logic ack_now;   // Handshake completes this cycle

    always_comb begin
        case (op)
            exec_pkg::cfu_beq:  taken = cmp.cmp_eq;
            exec_pkg::cfu_bne:  taken = !cmp.cmp_eq;
            exec_pkg::cfu_blt:  taken = cmp.cmp_lt;
            exec_pkg::cfu_bge:  taken = !cmp.cmp_lt;
            exec_pkg::cfu_bltu: taken = cmp.cmp_ltu;
            exec_pkg::cfu_bgeu: taken = !cmp.cmp_ltu;
            exec_pkg::cfu_jal:  taken = 1'b1;
            exec_pkg::cfu_jalr: taken = 1'b1;
            default:            taken = 1'b0; // Plain ALU instruction
        endcase
    end

    assign cf_need  = valid && taken;
    assign cf_valid = cf_need && !ack_seen;   // Drop once acked
    assign ack_now  = cf_valid && cf_ack;

    // Done if nothing to request, or fetch has taken it now or before
    assign finished = !cf_need || ack_now || ack_seen;

    // ------------------------------
    // Ack tracking
    // ------------------------------

    always_ff @(posedge g_clk) begin
        if (!g_resetn || accept || !valid) begin
            ack_seen <= 1'b0;                 // New instruction starts clean
        end else if (ack_now) begin
            ack_seen <= 1'b1;                 // Hold until the instruction leaves
        end
    end

    // ------------------------------
    // Target calculation
    // ------------------------------

    logic [`EXEC_XLEN-1:0] pc_target;  // Branches and jal
    logic [`EXEC_XLEN-1:0] reg_target; // jalr, before bit 0 is cleared

    assign pc_target  = pc + imm;
    assign reg_target = rs1_data + imm;

    assign cf_target = (op == exec_pkg::cfu_jalr) ?
                       {reg_target[`EXEC_XLEN-1:1], 1'b0} : // jalr clears bit 0
                       pc_target;

endmodule

/* logic/exec_cmp_if.sv */
// Adder and compare results passed from the ALU to the control flow unit
// Purely combinational, valid whenever the ALU operands are

`include "exec_defines.svh"

interface exec_cmp_if;

    logic [`EXEC_XLEN-1:0] add_out; // lhs + rhs
    logic                  cmp_eq;  // lhs == rhs
    logic                  cmp_lt;  // lhs <  rhs, signed
    logic                  cmp_ltu; // lhs <  rhs, unsigned

    // ALU side produces everything
    modport alu (output add_out, cmp_eq, cmp_lt, cmp_ltu);

    // CFU side only consumes
    modport cfu (input add_out, cmp_eq, cmp_lt, cmp_ltu);

endinterface

/* logic/exec_defines.svh */
// Width definitions shared by the execute stage and its testbench
// XLEN is fixed at 32, there is no RV64 word support
// Register file has 32 entries, so x0 is address zero

`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// ------------------------------
// Datapath widths
// ------------------------------

`define EXEC_XLEN        32 // Data and address width

`define EXEC_REG_ADDR_W  5  // Register address width

`endif

/* logic/exec_pkg.sv */
// Operation and source encodings for the execute stage
// Decode must drive exactly one of these codes per instruction
// Unlisted codes behave as a zero ALU result or no control flow

package exec_pkg;

    // ------------------------------
    // ALU operations
    // ------------------------------
    typedef enum logic [3:0] {
        alu_add  = 4'd0, // lhs + rhs
        alu_sub  = 4'd1, // lhs - rhs
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_sll  = 4'd5, // Shift by rhs[4:0]
        alu_srl  = 4'd6,
        alu_sra  = 4'd7, // Sign filling shift
        alu_slt  = 4'd8, // Signed set less than
        alu_sltu = 4'd9  // Unsigned set less than
    } alu_op_t;

    // ------------------------------
    // Control flow operations
    // ------------------------------
    typedef enum logic [3:0] {
        cfu_none = 4'd0, // Not a control flow instruction
        cfu_beq  = 4'd1,
        cfu_bne  = 4'd2,
        cfu_blt  = 4'd3,
        cfu_bge  = 4'd4,
        cfu_bltu = 4'd5,
        cfu_bgeu = 4'd6,
        cfu_jal  = 4'd7, // Always taken, pc relative
        cfu_jalr = 4'd8  // Always taken, register relative
    } cfu_op_t;

    // Writeback data source
    typedef enum logic [1:0] {
        wb_none = 2'd0, // No register write
        wb_alu  = 2'd1, // ALU result
        wb_npc  = 2'd2  // Link address for jal and jalr
    } wb_src_t;

endpackage

/* logic/exec_stage.sv */
// Execute stage top level, one instruction in flight at a time
// Decode must hold all s2_* inputs stable while s2_valid is high
// and s2_ready is low

`include "exec_defines.svh"

module exec_stage (
    input  logic                        g_clk,
    input  logic                        g_resetn,
    input  logic                        s2_valid,     // Decode instruction valid
    output logic                        s2_ready,     // Stage ready for it
    input  logic [`EXEC_XLEN-1:0]       s2_pc,        // Current program counter
    input  logic [`EXEC_XLEN-1:0]       s2_npc,       // Next program counter
    input  logic [`EXEC_XLEN-1:0]       s2_imm,       // Immediate
    input  logic [`EXEC_XLEN-1:0]       s2_rs1_data,  // RS1 value for jalr
    input  logic [`EXEC_XLEN-1:0]       s2_alu_lhs,
    input  logic [`EXEC_XLEN-1:0]       s2_alu_rhs,
    input  exec_pkg::alu_op_t           s2_alu_op,
    input  exec_pkg::cfu_op_t           s2_cfu_op,
    input  exec_pkg::wb_src_t           s2_wb_src,
    input  logic [`EXEC_REG_ADDR_W-1:0] s2_rd,        // Destination register
    input  logic                        s2_flush,     // Flush writeback register
    output logic                        s2_cf_valid,  // Control flow change request
    output logic [`EXEC_XLEN-1:0]       s2_cf_target, // Destination address
    input  logic                        s2_cf_ack,    // Fetch took the request
    output logic                        s3_valid,     // Instruction for writeback
    input  logic                        s3_ready,     // Writeback can accept
    output logic                        s3_full,
    output logic [`EXEC_XLEN-1:0]       s3_pc,
    output logic [`EXEC_XLEN-1:0]       s3_wdata,
    output logic [`EXEC_REG_ADDR_W-1:0] s3_rd,
    output logic                        s3_wen
);

    // ------------------------------
    // Internal nets
    // ------------------------------

    logic [`EXEC_XLEN-1:0] alu_result;
    logic                  cfu_finished; // No pending control flow
    logic                  accept;       // Instruction leaves decode

    exec_cmp_if cmp_bus ();              // ALU to CFU

    exec_alu u_alu (
        .lhs      (s2_alu_lhs),
        .rhs      (s2_alu_rhs),
        .op       (s2_alu_op),
        .result   (alu_result),
        .cmp      (cmp_bus.alu)
    );

    exec_cfu u_cfu (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .valid     (s2_valid),
        .accept    (accept),
        .op        (s2_cfu_op),
        .pc        (s2_pc),
        .rs1_data  (s2_rs1_data),
        .imm       (s2_imm),
        .cmp       (cmp_bus.cfu),
        .cf_valid  (s2_cf_valid),
        .cf_ack    (s2_cf_ack),
        .cf_target (s2_cf_target),
        .finished  (cfu_finished)
    );

    exec_wb_reg u_wb_reg (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .flush      (s2_flush),
        .s2_valid   (s2_valid),
        .finished   (cfu_finished),
        .s3_ready   (s3_ready),
        .s2_ready   (s2_ready),
        .s3_valid   (s3_valid),
        .accept     (accept),
        .pc         (s2_pc),
        .npc        (s2_npc),
        .rd         (s2_rd),
        .alu_result (alu_result),
        .wb_src     (s2_wb_src),
        .s3_full    (s3_full),
        .s3_pc      (s3_pc),
        .s3_wdata   (s3_wdata),
        .s3_rd      (s3_rd),
        .s3_wen     (s3_wen)
    );

endmodule

/* logic/exec_wb_reg.sv */
// Stage handshake and the writeback pipeline register
// s3_full stays high after a transfer until reset or flush, as the
// writeback stage reads the register while s3_full is set
// Payload fields only change on a transfer

`include "exec_defines.svh"

module exec_wb_reg (
    input  logic                        g_clk,
    input  logic                        g_resetn,
    input  logic                        flush,      // Drop register contents
    input  logic                        s2_valid,   // Decode has an instruction
    input  logic                        finished,   // CFU has nothing pending
    input  logic                        s3_ready,   // Writeback can take more
    output logic                        s2_ready,   // Stage takes the instruction
    output logic                        s3_valid,   // Instruction ready for writeback
    output logic                        accept,     // Transfer this cycle
    input  logic [`EXEC_XLEN-1:0]       pc,
    input  logic [`EXEC_XLEN-1:0]       npc,        // Link address
    input  logic [`EXEC_REG_ADDR_W-1:0] rd,
    input  logic [`EXEC_XLEN-1:0]       alu_result,
    input  exec_pkg::wb_src_t           wb_src,     // Writeback data select
    output logic                        s3_full,    // Register holds an instruction
    output logic [`EXEC_XLEN-1:0]       s3_pc,
    output logic [`EXEC_XLEN-1:0]       s3_wdata,
    output logic [`EXEC_REG_ADDR_W-1:0] s3_rd,
    output logic                        s3_wen      // Register file write
);

    // ------------------------------
    // Handshake
    // ------------------------------

    assign s3_valid = s2_valid && finished;
    assign s2_ready = s3_ready && finished;
    assign accept   = s2_valid && s2_ready;     // Same as s3_valid && s3_ready

    logic [`EXEC_XLEN-1:0] n_wdata;             // Next writeback data
    logic                  n_wen;               // Next write enable

    always_comb begin
        case (wb_src)
            exec_pkg::wb_alu: n_wdata = alu_result;
            exec_pkg::wb_npc: n_wdata = npc;
            default:          n_wdata = '0;     // Nothing to write
        endcase
    end

    // x0 is never written
    assign n_wen = (wb_src != exec_pkg::wb_none) && (rd != '0);

    // ------------------------------
    // Pipeline register
    // ------------------------------

    always_ff @(posedge g_clk) begin
        if (!g_resetn || flush) begin
            s3_full <= 1'b0;
            s3_wen  <= 1'b0;                    // No write without an instruction
        end else if (accept) begin
            s3_full <= 1'b1;
            s3_wen  <= n_wen;
        end
    end

    always_ff @(posedge g_clk) begin
        if (accept) begin
            s3_pc    <= pc;
            s3_rd    <= rd;
            s3_wdata <= n_wdata;
        end
    end

endmodule

/* verification/exec_assertions.sv */
// Handshake and pipeline register checks for the execute stage
// Assumes decode holds s2_* stable while s2_valid is high and s2_ready is low
// Bound into every exec_stage instance as u_checks

`include "exec_defines.svh"

module exec_assertions (
    input logic                        g_clk,
    input logic                        g_resetn,
    input logic                        s2_valid,
    input logic                        s2_ready,
    input logic                        s2_flush,
    input logic                        s2_cf_valid,
    input logic                        s2_cf_ack,
    input logic [`EXEC_XLEN-1:0]       s2_cf_target,
    input logic                        s3_valid,
    input logic                        s3_ready,
    input logic                        s3_full,
    input logic [`EXEC_XLEN-1:0]       s3_pc,
    input logic [`EXEC_XLEN-1:0]       s3_wdata,
    input logic [`EXEC_REG_ADDR_W-1:0] s3_rd,
    input logic                        s3_wen
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0; // Failed assertions so far

    task automatic count_failure(input string what);
        $error("%s", what);
        fail_count++;
    endtask

    // ------------------------------
    // Control flow request
    // ------------------------------

    a_cf_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
        s2_cf_valid && !s2_cf_ack |=> s2_cf_valid && $stable(s2_cf_target))
        else count_failure("control flow request dropped or target moved before ack");

    a_cf_wait: assert property (@(posedge g_clk) disable iff (!g_resetn)
        s2_cf_valid && !s2_cf_ack |-> !s3_valid) // Nothing moves on before the ack
        else count_failure("instruction offered to writeback before its ack");

    a_xfer: assert property (@(posedge g_clk) disable iff (!g_resetn)
        s2_valid && s2_ready |-> s3_valid && s3_ready) // Decode and writeback agree
        else count_failure("instruction accepted without a transfer into writeback");

    // ------------------------------
    // Back-pressure and clearing
    // ------------------------------

    a_bp_ready: assert property (@(posedge g_clk) disable iff (!g_resetn)
        !s3_ready |-> !s2_ready)
        else count_failure("stage ready while writeback stalls");

    a_bp_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
        !s3_ready && !s2_flush |=> $stable(s3_full) && $stable(s3_pc) && $stable(s3_wdata)
            && $stable(s3_rd) && $stable(s3_wen))
        else count_failure("writeback register changed during a stall");

    a_reset: assert property (@(posedge g_clk)
        !g_resetn |=> !s3_full && !s3_wen && !s2_cf_valid)
        else count_failure("register or request still set after reset");

    a_flush: assert property (@(posedge g_clk) disable iff (!g_resetn)
        s2_flush |=> !s3_full && !s3_wen)
        else count_failure("writeback register still full after flush");

    a_wen: assert property (@(posedge g_clk) disable iff (!g_resetn)
        !s3_full |-> !s3_wen) // Empty register never writes
        else count_failure("write enable set while register empty");

endmodule

bind exec_stage exec_assertions u_checks (.*);

/* verification/exec_tb.sv */
// Randomized testbench for the execute stage
// One instruction is issued at a time and its writeback register is checked
// in the cycle after it transfers; protocol checks sit in the bound checker

`include "exec_defines.svh"

module exec_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int W        = `EXEC_XLEN;
    localparam int N_INSTR  = 120;                          // All tests together
    localparam int WATCH_NS = (N_INSTR * 10 + 16 + 4) * 40; // 10 cycles each plus reset

    logic g_clk = 1'b0;
    logic g_resetn, s2_valid, s2_ready, s2_flush, s3_valid, s3_ready, s3_full, s3_wen;
    logic s2_cf_valid, s2_cf_ack;
    logic [W-1:0] s2_pc, s2_npc, s2_imm, s2_rs1_data, s2_alu_lhs, s2_alu_rhs;
    logic [W-1:0] s2_cf_target, s3_pc, s3_wdata;
    logic [`EXEC_REG_ADDR_W-1:0] s2_rd, s3_rd;
    exec_pkg::alu_op_t s2_alu_op;
    exec_pkg::cfu_op_t s2_cfu_op;
    exec_pkg::wb_src_t s2_wb_src;

    int           errors     = 0; // Writeback side failures
    int           cf_errors  = 0; // Target failures seen by the fetch model
    int           acks       = 0; // Completed control flow handshakes
    logic [W-1:0] exp_target;     // Target of the instruction in flight

    exec_stage dut0 (.*);

    initial begin
        forever #20 g_clk = ~g_clk; // 40 ns period
    end

    initial begin
        #(WATCH_NS);
        $display("timeout: no progress within %0d ns", WATCH_NS);
        $display("Simulation failed");
        $finish;
    end

    // ------------------------------
    // Reference model
    // ------------------------------

    function automatic logic [W-1:0] alu_model(exec_pkg::alu_op_t op, logic [W-1:0] a,
                                               logic [W-1:0] b);
        case (op)
            exec_pkg::alu_add: return a + b;
            exec_pkg::alu_sub: return a - b;
            exec_pkg::alu_and: return a & b;
            exec_pkg::alu_or:  return a | b;
            exec_pkg::alu_xor: return a ^ b;
            exec_pkg::alu_sll: return a << b[4:0];
            exec_pkg::alu_srl: return a >> b[4:0];
            exec_pkg::alu_sra: return $signed(a) >>> b[4:0]; // Sign fill
            exec_pkg::alu_slt: return {{(W-1){1'b0}}, $signed(a) < $signed(b)};
            default:           return {{(W-1){1'b0}}, a < b};   // sltu
        endcase
    endfunction

    function automatic bit branch_taken(exec_pkg::cfu_op_t op, logic [W-1:0] a,
                                        logic [W-1:0] b);
        case (op)
            exec_pkg::cfu_beq:  return a == b;
            exec_pkg::cfu_bne:  return a != b;
            exec_pkg::cfu_blt:  return $signed(a) < $signed(b);
            exec_pkg::cfu_bge:  return $signed(a) >= $signed(b);
            exec_pkg::cfu_bltu: return a < b;
            exec_pkg::cfu_bgeu: return a >= b;
            exec_pkg::cfu_jal, exec_pkg::cfu_jalr: return 1'b1;
            default:            return 1'b0; // Plain ALU instruction
        endcase
    endfunction

    function automatic int total_errors();
        return errors + cf_errors + dut0.u_checks.fail_count;
    endfunction

    task automatic expect_equal(input string name, input logic [W-1:0] got,
                                input logic [W-1:0] want);
        assert (got == want) else begin
            $display("mismatch %s: got %h expected %h", name, got, want);
            errors++;
        end
    endtask

    // ------------------------------
    // Writeback and fetch models
    // ------------------------------

    initial begin
        s3_ready = 1'b1;
        forever begin
            @(posedge g_clk);
            #2 s3_ready = ($urandom % 4) != 0; // Stall about one cycle in four
        end
    end

    initial begin
        int unsigned delay;
        s2_cf_ack = 1'b0;
        forever begin
            @(negedge g_clk);
            if (s2_cf_valid) begin
                delay = $urandom % 4;               // 0 to 3 cycles
                repeat (delay) @(posedge g_clk);
                @(posedge g_clk);
                #2 s2_cf_ack = 1'b1;
                @(negedge g_clk);
                acks++;
                assert (s2_cf_target == exp_target) else begin
                    $display("mismatch s2_cf_target: got %h expected %h",
                             s2_cf_target, exp_target);
                    cf_errors++;
                end
                @(posedge g_clk);                   // Handshake completes here
                #2 s2_cf_ack = 1'b0;
            end
        end
    end

    // ------------------------------
    // Decode side stimulus
    // ------------------------------

    task automatic issue(input exec_pkg::alu_op_t aop, input exec_pkg::cfu_op_t cop,
                         input exec_pkg::wb_src_t src, input logic flush);
        logic [W-1:0] want;  // Expected writeback data
        logic [W-1:0] draw;
        bit           taken;
        int           acks_before;
        @(posedge g_clk);
        #2;
        draw        = $urandom;
        s2_alu_lhs  = $urandom;
        s2_alu_rhs  = (draw[1:0] == 2'b00) ? s2_alu_lhs : $urandom; // Equal now and then
        s2_pc       = $urandom & 32'hffff_fffc;
        s2_npc      = s2_pc + 4;
        s2_imm      = $urandom;
        s2_rs1_data = $urandom;
        s2_rd       = draw[8:4];                   // x0 included
        s2_alu_op   = aop;
        s2_cfu_op   = cop;
        s2_wb_src   = src;
        s2_flush    = flush;
        s2_valid    = 1'b1;
        acks_before = acks;
        taken       = branch_taken(cop, s2_alu_lhs, s2_alu_rhs);
        exp_target  = (cop == exec_pkg::cfu_jalr) ?
                      ((s2_rs1_data + s2_imm) & ~32'h1) : s2_pc + s2_imm;
        case (src)
            exec_pkg::wb_alu: want = alu_model(aop, s2_alu_lhs, s2_alu_rhs);
            exec_pkg::wb_npc: want = s2_npc;        // Link address
            default:          want = '0;
        endcase
        @(negedge g_clk);
        while (!s2_ready) @(negedge g_clk);         // Ack and stall wait
        @(posedge g_clk);
        #2;
        s2_valid = 1'b0;
        s2_flush = 1'b0;
        @(negedge g_clk);
        assert (acks - acks_before == int'(taken)) else begin
            $display("control flow request %s for %s",
                     taken ? "missing" : "unexpected", cop.name());
            errors++;
        end
        expect_equal("s3_full", W'(s3_full), W'(!flush));
        expect_equal("s3_wen", W'(s3_wen),
                     W'(!flush && src != exec_pkg::wb_none && s2_rd != '0));
        if (!flush) begin
            expect_equal("s3_wdata", s3_wdata, want);
            expect_equal("s3_pc", s3_pc, s2_pc);
            expect_equal("s3_rd", W'(s3_rd), W'(s2_rd));
        end
    endtask

    task automatic run_test(input string name, input int count, input int kind);
        int                start;
        exec_pkg::alu_op_t aop;
        exec_pkg::cfu_op_t cop;
        start = total_errors();
        for (int i = 0; i < count; i++) begin
            aop = exec_pkg::alu_op_t'(4'($urandom % 10));
            cop = exec_pkg::cfu_op_t'(4'(1 + $urandom % 6)); // One of the branches
            case (kind)
                0: issue(aop, exec_pkg::cfu_none, exec_pkg::wb_alu, 1'b0);
                1: issue(aop, cop, exec_pkg::wb_none, 1'b0);
                2: issue(aop, ($urandom % 2 != 0) ? exec_pkg::cfu_jal : exec_pkg::cfu_jalr,
                         exec_pkg::wb_npc, 1'b0);
                default: issue(aop, exec_pkg::cfu_none, exec_pkg::wb_alu, 1'b1);
            endcase
        end
        $display("test %-6s %0d instructions, %0d errors", name, count, total_errors() - start);
    endtask

    initial begin
        void'($urandom(32'h8b1e));
        g_resetn    = 1'b0;
        s2_valid    = 1'b0;
        s2_flush    = 1'b0;
        s2_pc       = '0;
        s2_npc      = '0;
        s2_imm      = '0;
        s2_rs1_data = '0;
        s2_alu_lhs  = '0;
        s2_alu_rhs  = '0;
        s2_rd       = '0;
        s2_alu_op   = exec_pkg::alu_add;
        s2_cfu_op   = exec_pkg::cfu_none;
        s2_wb_src   = exec_pkg::wb_none;
        repeat (16) @(posedge g_clk);
        #2 g_resetn = 1'b1;
        repeat (3) @(posedge g_clk);               // Idle before the first instruction
        run_test("alu", 60, 0);
        run_test("branch", 40, 1);
        run_test("jump", 16, 2);
        run_test("flush", 4, 3);
        $display("tests 4, instructions %0d, errors %0d", N_INSTR, total_errors());
        if (total_errors() == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
